// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

obj_dir/Vbackend_tb: src.f $(wildcard logic/*.sv tests/*.sv)
	verilator --binary --timing -j 0 --top-module backend_tb -f src.f

test: obj_dir/Vbackend_tb
	@out=$$(./obj_dir/Vbackend_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

// ==== logic/backend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_top
    import ooo_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    // dispatch
    input  logic                  disp_valid,
    input  op_t                   disp_op,
    input  logic [REG_ADDR_W-1:0] disp_rd,
    input  logic [REG_ADDR_W-1:0] disp_st_src,
    input  logic                  disp_pred_taken,
    output logic                  rob_full,
    output logic [TAG_W-1:0]      disp_tag,
    // common data bus
    input  logic                  cdb_valid,
    input  logic [TAG_W-1:0]      cdb_tag,
    input  logic [XLEN-1:0]       cdb_value,
    input  logic                  cdb_br_taken,
    // operand read
    input  logic [REG_ADDR_W-1:0] rs_addr,
    output logic [XLEN-1:0]       rs_value,
    output logic                  rs_busy,
    output logic [TAG_W-1:0]      rs_tag,
    // data memory
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [XLEN-1:0]       wb_adr,
    output logic [3:0]            wb_sel,
    output logic [XLEN-1:0]       wb_dat_w,
    input  logic                  wb_ack,
    input  logic [XLEN-1:0]       wb_dat_r,
    // recovery toward fetch
    output logic                  redirect,
    output logic [TAG_W-1:0]      redirect_tag
);

    logic                  commit_en;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic [TAG_W-1:0]      commit_tag;
    logic [XLEN-1:0]       commit_value;
    logic                  head_mem_req;
    op_t                   head_op;
    logic [XLEN-1:0]       head_addr;
    logic [REG_ADDR_W-1:0] head_st_src;
    logic                  mem_done;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       st_data;
    logic                  flush;
    logic                  alloc_en;

    // rename on accepted alu and load dispatch
    assign alloc_en = disp_valid & ~rob_full & writes_rd(disp_op);

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_rd         (disp_rd),
        .disp_st_src     (disp_st_src),
        .disp_pred_taken (disp_pred_taken),
        .rob_full        (rob_full),
        .disp_tag        (disp_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_br_taken    (cdb_br_taken),
        .commit_en       (commit_en),
        .commit_rd       (commit_rd),
        .commit_tag      (commit_tag),
        .commit_value    (commit_value),
        .head_mem_req    (head_mem_req),
        .head_op         (head_op),
        .head_addr       (head_addr),
        .head_st_src     (head_st_src),
        .mem_done        (mem_done),
        .load_data       (load_data),
        .redirect        (redirect),
        .redirect_tag    (redirect_tag),
        .flush           (flush)
    );

    reg_status #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_reg_status (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc_rd     (disp_rd),
        .alloc_tag    (disp_tag),
        .commit_en    (commit_en),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .commit_value (commit_value),
        .flush        (flush),
        .rs_addr      (rs_addr),
        .rs_value     (rs_value),
        .rs_busy      (rs_busy),
        .rs_tag       (rs_tag),
        .st_src       (head_st_src),
        .st_data      (st_data)
    );

    commit_mem_port u_commit_mem_port (
        .clk          (clk),
        .rst          (rst),
        .head_mem_req (head_mem_req),
        .head_op      (head_op),
        .head_addr    (head_addr),
        .st_data      (st_data),
        .mem_done     (mem_done),
        .load_data    (load_data),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_sel       (wb_sel),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r)
    );

endmodule

`default_nettype wire

// ==== logic/commit_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_mem_port
    import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    // head of the rob
    input  logic            head_mem_req,
    input  op_t             head_op,
    input  logic [XLEN-1:0] head_addr,
    input  logic [XLEN-1:0] st_data,
    output logic            mem_done,
    output logic [XLEN-1:0] load_data,
    // wishbone classic master
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output logic [XLEN-1:0] wb_adr,
    output logic [3:0]      wb_sel,
    output logic [XLEN-1:0] wb_dat_w,
    input  logic            wb_ack,
    input  logic [XLEN-1:0] wb_dat_r
);

    // idle when low, bus cycle open when high
    logic busy;

    logic [1:0]      offset;
    logic [4:0]      shamt;
    logic [XLEN-1:0] rd_shifted;
    logic [3:0]      lane_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy) begin
            busy <= head_mem_req;
        end else if (wb_ack) begin
            // rob advances on this edge, next op restarts from idle
            busy <= 1'b0;
        end
    end

    assign mem_done = busy & wb_ack;

    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = busy & is_store(head_op);
    assign wb_adr = {head_addr[XLEN-1:2], 2'b00};
    assign wb_sel = lane_mask;

    assign offset = head_addr[1:0];
    assign shamt  = {offset, 3'b000};

    // byte lanes from access size and offset
    always_comb begin
        case (head_op)
            op_sb, op_lb, op_lbu: lane_mask = 4'b0001 << offset;
            op_sh, op_lh, op_lhu: lane_mask = 4'b0011 << offset;
            default:              lane_mask = 4'b1111;
        endcase
    end

    // store data copied into the selected lanes
    always_comb begin
        case (head_op)
            op_sb: wb_dat_w = {4{st_data[7:0]}};
            // odd offset rotates the halfword by one lane
            op_sh: wb_dat_w = offset[0] ? {st_data[7:0], st_data[15:0], st_data[15:8]}
                                        : {2{st_data[15:0]}};
            default: wb_dat_w = st_data;
        endcase
    end

    // addressed byte moved down to lane 0
    assign rd_shifted = wb_dat_r >> shamt;

    always_comb begin
        case (head_op)
            op_lb:   load_data = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            op_lbu:  load_data = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
            op_lh:   load_data = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            op_lhu:  load_data = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
            default: load_data = wb_dat_r;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // data and address width
    localparam int XLEN = 32;
    // architectural register index width
    localparam int REG_ADDR_W = 5;

    // operation classes seen by the commit stage
    typedef enum logic [3:0] {
        op_alu    = 4'd0,
        op_branch = 4'd1,
        op_lb     = 4'd2,
        op_lh     = 4'd3,
        op_lw     = 4'd4,
        op_lbu    = 4'd5,
        op_lhu    = 4'd6,
        op_sb     = 4'd7,
        op_sh     = 4'd8,
        op_sw     = 4'd9
    } op_t;

    // rob destination field
    // register number for alu, load and store ops, outcome bits for branches
    typedef union packed {
        logic [REG_ADDR_W-1:0] reg_idx;
        struct packed {
            logic [2:0] pad;
            logic       predicted;
            logic       taken;
        } br;
    } rob_dest_u;

    function automatic logic is_load(op_t op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    function automatic logic is_store(op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    // ops that rename a destination register
    function automatic logic writes_rd(op_t op);
        return (op == op_alu) || is_load(op);
    endfunction

endpackage

`default_nettype wire

// ==== logic/reg_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_status
    import ooo_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    // rename at dispatch
    input  logic                  alloc_en,
    input  logic [REG_ADDR_W-1:0] alloc_rd,
    input  logic [TAG_W-1:0]      alloc_tag,
    // write at commit
    input  logic                  commit_en,
    input  logic [REG_ADDR_W-1:0] commit_rd,
    input  logic [TAG_W-1:0]      commit_tag,
    input  logic [XLEN-1:0]       commit_value,
    input  logic                  flush,
    // read port a, operand lookup
    input  logic [REG_ADDR_W-1:0] rs_addr,
    output logic [XLEN-1:0]       rs_value,
    output logic                  rs_busy,
    output logic [TAG_W-1:0]      rs_tag,
    // read port b, store data
    input  logic [REG_ADDR_W-1:0] st_src,
    output logic [XLEN-1:0]       st_data
);

    localparam int NREGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0]  regs    [NREGS];
    logic [TAG_W-1:0] tag_arr [NREGS];
    logic [NREGS-1:0] busy_vec;

    // x0 is never renamed
    logic alloc_live;
    logic commit_live;

    assign alloc_live  = alloc_en & (alloc_rd != '0);
    assign commit_live = commit_en & (commit_rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_vec <= '0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_live) begin
                regs[commit_rd] <= commit_value;
                // a younger rename keeps the register busy
                if (tag_arr[commit_rd] == commit_tag) begin
                    busy_vec[commit_rd] <= 1'b0;
                end
            end
            // same-edge rename wins over the commit clear
            if (alloc_live) begin
                busy_vec[alloc_rd] <= 1'b1;
            end
            if (flush) begin
                busy_vec <= '0;
            end
        end
    end

    // rename tags, only meaningful while busy
    always_ff @(posedge clk) begin
        if (alloc_live) begin
            tag_arr[alloc_rd] <= alloc_tag;
        end
    end

    assign rs_value = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rs_busy  = busy_vec[rs_addr];
    assign rs_tag   = tag_arr[rs_addr];
    assign st_data  = (st_src == '0) ? '0 : regs[st_src];

endmodule

`default_nettype wire

// ==== logic/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob
    import ooo_pkg::*;
#(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    // dispatch, in program order
    input  logic                  disp_valid,
    input  op_t                   disp_op,
    input  logic [REG_ADDR_W-1:0] disp_rd,
    input  logic [REG_ADDR_W-1:0] disp_st_src,
    input  logic                  disp_pred_taken,
    output logic                  rob_full,
    output logic [TAG_W-1:0]      disp_tag,
    // common data bus
    input  logic                  cdb_valid,
    input  logic [TAG_W-1:0]      cdb_tag,
    input  logic [XLEN-1:0]       cdb_value,
    input  logic                  cdb_br_taken,
    // register file commit
    output logic                  commit_en,
    output logic [REG_ADDR_W-1:0] commit_rd,
    output logic [TAG_W-1:0]      commit_tag,
    output logic [XLEN-1:0]       commit_value,
    // memory port
    output logic                  head_mem_req,
    output op_t                   head_op,
    output logic [XLEN-1:0]       head_addr,
    output logic [REG_ADDR_W-1:0] head_st_src,
    input  logic                  mem_done,
    input  logic [XLEN-1:0]       load_data,
    // recovery
    output logic                  redirect,
    output logic [TAG_W-1:0]      redirect_tag,
    output logic                  flush
);

    // entry payload
    op_t             op_arr    [ROB_DEPTH];
    rob_dest_u       dest_arr  [ROB_DEPTH];
    // address for memory ops, result otherwise
    logic [XLEN-1:0] value_arr [ROB_DEPTH];

    // entry status
    logic [ROB_DEPTH-1:0] alloc_vec;
    logic [ROB_DEPTH-1:0] done_vec;

    // head == tail means empty, full leaves one slot open
    logic [TAG_W-1:0] head_ptr;
    logic [TAG_W-1:0] tail_ptr;
    logic [TAG_W-1:0] head_next;
    logic [TAG_W-1:0] tail_next;

    logic             flush_q;
    logic [TAG_W-1:0] flush_tag_q;

    logic      disp_accept;
    rob_dest_u disp_dest;
    logic      cdb_hit;
    op_t       h_op;
    rob_dest_u h_dest;
    logic      h_ready;
    logic      h_is_mem;
    logic      h_mispredict;
    logic      h_retire;

    assign head_next = head_ptr + 1'b1;
    assign tail_next = tail_ptr + 1'b1;

    // also full while recovering so the tail stays put
    assign rob_full    = (tail_next == head_ptr) | flush_q;
    assign disp_accept = disp_valid & ~rob_full;
    assign disp_tag    = tail_ptr;

    // completion only counts for live entries
    assign cdb_hit = cdb_valid & alloc_vec[cdb_tag];

    // pack dispatch fields into the dest union
    always_comb begin
        disp_dest = '0;
        if (is_store(disp_op)) begin
            disp_dest.reg_idx = disp_st_src;
        end else if (disp_op == op_branch) begin
            // outcome unknown until the cdb reports it
            disp_dest.br.predicted = disp_pred_taken;
            disp_dest.br.taken     = 1'b0;
        end else begin
            disp_dest.reg_idx = disp_rd;
        end
    end

    // head decode
    assign h_op     = op_arr[head_ptr];
    assign h_dest   = dest_arr[head_ptr];
    assign h_ready  = alloc_vec[head_ptr] & done_vec[head_ptr] & ~flush_q;
    assign h_is_mem = is_load(h_op) | is_store(h_op);

    assign h_mispredict = h_ready & (h_op == op_branch) &
                          (h_dest.br.predicted != h_dest.br.taken);

    // memory ops wait for the bus, mispredicts go through the flush cycle
    assign h_retire = h_ready & (h_is_mem ? mem_done : ~h_mispredict);

    // commit toward the register file
    assign commit_en    = h_ready & ((h_op == op_alu) | (is_load(h_op) & mem_done));
    assign commit_rd    = h_dest.reg_idx;
    assign commit_tag   = head_ptr;
    assign commit_value = is_load(h_op) ? load_data : value_arr[head_ptr];

    // head memory request
    assign head_mem_req = h_ready & h_is_mem;
    assign head_op      = h_op;
    assign head_addr    = value_arr[head_ptr];
    assign head_st_src  = h_dest.reg_idx;

    // single recovery cycle
    assign redirect     = flush_q;
    assign redirect_tag = flush_tag_q;
    assign flush        = flush_q;

    // payload writes
    always_ff @(posedge clk) begin
        if (disp_accept) begin
            op_arr[tail_ptr]   <= disp_op;
            dest_arr[tail_ptr] <= disp_dest;
        end
        if (cdb_hit) begin
            if (op_arr[cdb_tag] == op_branch) begin
                dest_arr[cdb_tag].br.taken <= cdb_br_taken;
            end else begin
                value_arr[cdb_tag] <= cdb_value;
            end
        end
    end

    // pointers, status flags and recovery
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_vec   <= '0;
            done_vec    <= '0;
            head_ptr    <= '0;
            tail_ptr    <= '0;
            flush_q     <= 1'b0;
            flush_tag_q <= '0;
        end else begin
            flush_q <= h_mispredict;
            if (h_mispredict) begin
                flush_tag_q <= head_ptr;
            end

            if (disp_accept) begin
                alloc_vec[tail_ptr] <= 1'b1;
                done_vec[tail_ptr]  <= 1'b0;
                tail_ptr            <= tail_next;
            end

            if (cdb_hit) begin
                done_vec[cdb_tag] <= 1'b1;
            end

            if (h_retire) begin
                alloc_vec[head_ptr] <= 1'b0;
                done_vec[head_ptr]  <= 1'b0;
                head_ptr            <= head_next;
            end

            // end of recovery cycle
            // drop everything, skip past the branch
            if (flush_q) begin
                alloc_vec <= '0;
                done_vec  <= '0;
                head_ptr  <= head_next;
                tail_ptr  <= head_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/ooo_pkg.sv
logic/rob.sv
logic/reg_status.sv
logic/commit_mem_port.sv
logic/backend_top.sv
tests/backend_tb.sv

// ==== tests/backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_tb
    import ooo_pkg::*;
();

    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int MEM_WORDS = 64;
    // reset 1, in order 5, full 7, stores 9, loads 8, branch 8
    localparam int INSTR_COUNT = 38;
    localparam int CYCLE_LIMIT = 40 * INSTR_COUNT + 100;
    localparam logic [XLEN-1:0] STORE_DATA = 32'ha1b2_c3d4;

    logic clk = 1'b0;
    logic rst;

    logic                  disp_valid;
    op_t                   disp_op;
    logic [REG_ADDR_W-1:0] disp_rd;
    logic [REG_ADDR_W-1:0] disp_st_src;
    logic                  disp_pred_taken;
    logic                  rob_full;
    logic [TAG_W-1:0]      disp_tag;
    logic                  cdb_valid;
    logic [TAG_W-1:0]      cdb_tag;
    logic [XLEN-1:0]       cdb_value;
    logic                  cdb_br_taken;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [XLEN-1:0]       rs_value;
    logic                  rs_busy;
    logic [TAG_W-1:0]      rs_tag;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [XLEN-1:0]       wb_adr;
    logic [3:0]            wb_sel;
    logic [XLEN-1:0]       wb_dat_w;
    logic                  wb_ack = 1'b0;
    logic [XLEN-1:0]       wb_dat_r = '0;
    logic                  redirect;
    logic [TAG_W-1:0]      redirect_tag;

    // memory model state
    logic [XLEN-1:0] mem     [MEM_WORDS];
    logic [XLEN-1:0] exp_mem [MEM_WORDS];
    logic [31:0]     lfsr = 32'h8e05_2718;
    logic [1:0]      draw;
    logic [1:0]      wait_left = 2'd0;
    logic            counting = 1'b0;
    logic            fire;
    int              ack_count = 0;
    // write enable of the last acked cycle
    logic            last_we = 1'b0;

    // redirect monitor
    int               redirect_cnt = 0;
    logic [TAG_W-1:0] redirect_seen_tag = '0;

    int cycles = 0;
    int checks = 0;
    int errors = 0;

    always #2 clk = ~clk;

    backend_top #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_backend_top (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_rd         (disp_rd),
        .disp_st_src     (disp_st_src),
        .disp_pred_taken (disp_pred_taken),
        .rob_full        (rob_full),
        .disp_tag        (disp_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_br_taken    (cdb_br_taken),
        .rs_addr         (rs_addr),
        .rs_value        (rs_value),
        .rs_busy         (rs_busy),
        .rs_tag          (rs_tag),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_sel          (wb_sel),
        .wb_dat_w        (wb_dat_w),
        .wb_ack          (wb_ack),
        .wb_dat_r        (wb_dat_r),
        .redirect        (redirect),
        .redirect_tag    (redirect_tag)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // preset contents, word 16 holds sign-rich bytes for the loads
    function automatic logic [XLEN-1:0] mem_fill(input int i);
        if (i == 16) begin
            return 32'h80f1_7fa5;
        end
        return 32'h9e37_79b9 * (i + 1);
    endfunction

    // addressed byte or halfword, then extended per op
    function automatic logic [XLEN-1:0] load_expect(input op_t op, input logic [31:0] word,
                                                    input int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[8*off +: 16];
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'h0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // wishbone slave, 0 to 3 wait cycles drawn from the lfsr
    always @(posedge clk) begin
        fire = 1'b0;
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= mem_fill(i);
            end
            wb_ack   <= 1'b0;
            counting <= 1'b0;
        end else if (wb_ack) begin
            // classic cycle ends on the ack edge
            wb_ack   <= 1'b0;
            counting <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!counting) begin
                lfsr      = lfsr_step(lfsr);
                draw[0]   = lfsr[0];
                lfsr      = lfsr_step(lfsr);
                draw[1]   = lfsr[0];
                fire      = (draw == 2'd0);
                counting  <= 1'b1;
                wait_left <= draw - 2'd1;
            end else if (wait_left == 2'd0) begin
                fire = 1'b1;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
        if (fire) begin
            wb_ack    <= 1'b1;
            wb_dat_r  <= mem[wb_adr[7:2]];
            ack_count <= ack_count + 1;
            last_we   <= wb_we;
            if (wb_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel[b]) begin
                        mem[wb_adr[7:2]][8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    // count redirect cycles and keep the last tag
    always @(posedge clk) begin
        if (!rst && redirect) begin
            redirect_cnt      <= redirect_cnt + 1;
            redirect_seen_tag <= redirect_tag;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // held until the accepting edge, tag sampled just before it
    task automatic dispatch_op(input op_t op, input logic [REG_ADDR_W-1:0] rd,
                               input logic [REG_ADDR_W-1:0] src, input logic pred,
                               output logic [TAG_W-1:0] tag);
        @(posedge clk);
        disp_valid      <= 1'b1;
        disp_op         <= op;
        disp_rd         <= rd;
        disp_st_src     <= src;
        disp_pred_taken <= pred;
        @(negedge clk);
        while (rob_full) begin
            @(negedge clk);
        end
        tag = disp_tag;
        @(posedge clk);
        disp_valid <= 1'b0;
    endtask

    // one cdb beat, returns on the completion edge
    task automatic cdb_complete(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] value,
                                input logic taken);
        @(posedge clk);
        cdb_valid    <= 1'b1;
        cdb_tag      <= tag;
        cdb_value    <= value;
        cdb_br_taken <= taken;
        @(posedge clk);
        cdb_valid <= 1'b0;
    endtask

    // port a settles by the next falling edge
    task automatic select_reg(input logic [REG_ADDR_W-1:0] r);
        @(posedge clk);
        rs_addr <= r;
        @(negedge clk);
    endtask

    task automatic wait_reg_idle(input logic [REG_ADDR_W-1:0] r);
        select_reg(r);
        while (rs_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic alu_write(input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] value);
        logic [TAG_W-1:0] tag;
        dispatch_op(op_alu, rd, 5'd0, 1'b0, tag);
        cdb_complete(tag, value, 1'b0);
        wait_reg_idle(rd);
        check($sformatf("r%0d", rd), rs_value, value);
    endtask

    task automatic store_at(input op_t op, input logic [XLEN-1:0] addr);
        logic [TAG_W-1:0] tag;
        int acks;
        int size;
        size = (op == op_sw) ? 4 : (op == op_sh) ? 2 : 1;
        acks = ack_count;
        dispatch_op(op, 5'd0, 5'd10, 1'b0, tag);
        // cdb carries the effective address for memory ops
        cdb_complete(tag, addr, 1'b0);
        while (ack_count == acks) begin
            @(negedge clk);
        end
        check("wb_we", 32'(last_we), 32'd1);
        // bus released the cycle after the ack edge
        @(negedge clk);
        check("wb_cyc", 32'(wb_cyc), 32'd0);
        check("wb_stb", 32'(wb_stb), 32'd0);
        // source byte k lands at byte offset+k
        for (int k = 0; k < size; k++) begin
            exp_mem[addr[7:2]][8*(addr[1:0] + k) +: 8] = STORE_DATA[8*k +: 8];
        end
    endtask

    task automatic load_at(input op_t op, input logic [XLEN-1:0] addr,
                           input logic [REG_ADDR_W-1:0] rd);
        logic [TAG_W-1:0] tag;
        dispatch_op(op, rd, 5'd0, 1'b0, tag);
        cdb_complete(tag, addr, 1'b0);
        wait_reg_idle(rd);
        check("wb_we", 32'(last_we), 32'd0);
        check($sformatf("r%0d", rd), rs_value,
              load_expect(op, exp_mem[addr[7:2]], int'(addr[1:0])));
    endtask

    task automatic reset_and_rename();
        logic [TAG_W-1:0] tag;
        @(negedge clk);
        check("rob_full", 32'(rob_full), 32'd0);
        check("wb_cyc", 32'(wb_cyc), 32'd0);
        check("wb_stb", 32'(wb_stb), 32'd0);
        check("redirect", 32'(redirect), 32'd0);
        check("commit_en", 32'(u_backend_top.commit_en), 32'd0);
        check("flush", 32'(u_backend_top.flush), 32'd0);
        for (int r = 0; r < 32; r++) begin
            select_reg(REG_ADDR_W'(r));
            check($sformatf("rs_busy r%0d", r), 32'(rs_busy), 32'd0);
        end
        dispatch_op(op_alu, 5'd5, 5'd0, 1'b0, tag);
        select_reg(5'd5);
        check("rs_busy r5", 32'(rs_busy), 32'd1);
        check("rs_tag r5", 32'(rs_tag), 32'(tag));
        cdb_complete(tag, 32'h0000_0555, 1'b0);
        wait_reg_idle(5'd5);
        check("r5", rs_value, 32'h0000_0555);
    endtask

    task automatic commit_in_order();
        logic [TAG_W-1:0] tags [3];
        logic [TAG_W-1:0] ta;
        logic [TAG_W-1:0] tb;
        for (int k = 0; k < 3; k++) begin
            dispatch_op(op_alu, REG_ADDR_W'(k + 1), 5'd0, 1'b0, tags[k]);
        end
        // youngest first
        for (int k = 2; k >= 0; k--) begin
            cdb_complete(tags[k], {16'hc0de, 16'(k + 1)}, 1'b0);
        end
        wait_reg_idle(5'd3);
        for (int k = 0; k < 3; k++) begin
            select_reg(REG_ADDR_W'(k + 1));
            check($sformatf("r%0d", k + 1), rs_value, {16'hc0de, 16'(k + 1)});
            check($sformatf("rs_busy r%0d", k + 1), 32'(rs_busy), 32'd0);
        end
        // two writers to r7
        dispatch_op(op_alu, 5'd7, 5'd0, 1'b0, ta);
        dispatch_op(op_alu, 5'd7, 5'd0, 1'b0, tb);
        select_reg(5'd7);
        check("rs_tag r7", 32'(rs_tag), 32'(tb));
        cdb_complete(ta, 32'h0000_0770, 1'b0);
        // older commits on this edge
        select_reg(5'd7);
        check("r7", rs_value, 32'h0000_0770);
        check("rs_busy r7", 32'(rs_busy), 32'd1);
        check("rs_tag r7", 32'(rs_tag), 32'(tb));
        cdb_complete(tb, 32'h0000_0771, 1'b0);
        wait_reg_idle(5'd7);
        check("r7", rs_value, 32'h0000_0771);
    endtask

    task automatic full_and_stall();
        logic [TAG_W-1:0] tags [ROB_DEPTH-1];
        for (int k = 0; k < ROB_DEPTH - 1; k++) begin
            dispatch_op(op_alu, REG_ADDR_W'(20 + k), 5'd0, 1'b0, tags[k]);
            @(negedge clk);
            check("rob_full", 32'(rob_full), 32'(k == ROB_DEPTH - 2));
        end
        cdb_complete(tags[0], 32'h2000_0014, 1'b0);
        // still full until the head commits
        @(negedge clk);
        check("rob_full", 32'(rob_full), 32'd1);
        @(negedge clk);
        check("rob_full", 32'(rob_full), 32'd0);
        for (int k = 1; k < ROB_DEPTH - 1; k++) begin
            cdb_complete(tags[k], 32'h2000_0014 + 32'(k), 1'b0);
        end
        wait_reg_idle(REG_ADDR_W'(20 + ROB_DEPTH - 2));
        check("last of full run", rs_value, 32'h2000_0014 + 32'(ROB_DEPTH - 2));
    endtask

    task automatic store_lanes();
        alu_write(5'd10, STORE_DATA);
        store_at(op_sw, 32'h0000_0080);
        store_at(op_sh, 32'h0000_0084);
        store_at(op_sh, 32'h0000_0089);
        store_at(op_sh, 32'h0000_008e);
        store_at(op_sb, 32'h0000_0090);
        store_at(op_sb, 32'h0000_0095);
        store_at(op_sb, 32'h0000_009a);
        store_at(op_sb, 32'h0000_009f);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
        end
    endtask

    task automatic load_extend();
        load_at(op_lb, 32'h0000_0040, 5'd11);
        load_at(op_lb, 32'h0000_0041, 5'd12);
        load_at(op_lbu, 32'h0000_0042, 5'd13);
        load_at(op_lb, 32'h0000_0043, 5'd14);
        load_at(op_lh, 32'h0000_0040, 5'd15);
        load_at(op_lh, 32'h0000_0042, 5'd16);
        load_at(op_lhu, 32'h0000_0042, 5'd17);
        load_at(op_lw, 32'h0000_0040, 5'd18);
    endtask

    task automatic branch_recovery();
        logic [TAG_W-1:0] br_tag;
        logic [TAG_W-1:0] t1;
        logic [TAG_W-1:0] t2;
        logic [TAG_W-1:0] next_tag;
        int seen;
        alu_write(5'd12, 32'h0000_1212);
        alu_write(5'd13, 32'h0000_1313);
        // predicted not taken, resolves taken
        dispatch_op(op_branch, 5'd0, 5'd0, 1'b0, br_tag);
        dispatch_op(op_alu, 5'd12, 5'd0, 1'b0, t1);
        dispatch_op(op_alu, 5'd13, 5'd0, 1'b0, t2);
        cdb_complete(t1, 32'hdead_0012, 1'b0);
        cdb_complete(t2, 32'hdead_0013, 1'b0);
        seen = redirect_cnt;
        cdb_complete(br_tag, 32'h0, 1'b1);
        while (redirect_cnt == seen) begin
            @(negedge clk);
        end
        // one cycle wide
        check("redirect", 32'(redirect), 32'd0);
        check("redirect_tag", 32'(redirect_seen_tag), 32'(br_tag));
        select_reg(5'd12);
        check("r12", rs_value, 32'h0000_1212);
        check("rs_busy r12", 32'(rs_busy), 32'd0);
        select_reg(5'd13);
        check("r13", rs_value, 32'h0000_1313);
        check("rs_busy r13", 32'(rs_busy), 32'd0);
        // no further redirect cycles since the pulse
        check("redirect pulses", redirect_cnt - seen, 32'd1);
        next_tag = br_tag + 1'b1;
        dispatch_op(op_alu, 5'd14, 5'd0, 1'b0, t1);
        check("disp_tag", 32'(t1), 32'(next_tag));
        cdb_complete(t1, 32'h0000_1414, 1'b0);
        wait_reg_idle(5'd14);
        check("r14", rs_value, 32'h0000_1414);
        // prediction matches, plain retire
        seen = redirect_cnt;
        dispatch_op(op_branch, 5'd0, 5'd0, 1'b1, br_tag);
        dispatch_op(op_alu, 5'd15, 5'd0, 1'b0, t2);
        cdb_complete(br_tag, 32'h0, 1'b1);
        cdb_complete(t2, 32'h0000_1515, 1'b0);
        wait_reg_idle(5'd15);
        check("r15", rs_value, 32'h0000_1515);
        check("redirect pulses", redirect_cnt - seen, 32'd0);
    endtask

    initial begin
        rst             = 1'b1;
        disp_valid      = 1'b0;
        disp_op         = op_alu;
        disp_rd         = '0;
        disp_st_src     = '0;
        disp_pred_taken = 1'b0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        cdb_value       = '0;
        cdb_br_taken    = 1'b0;
        rs_addr         = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            exp_mem[i] = mem_fill(i);
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        reset_and_rename();
        commit_in_order();
        full_and_stall();
        store_lanes();
        load_extend();
        branch_recovery();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
